// File: verilog/ntm_trainer_pkg.sv
// Q8.8 signed fixed point throughout. Every product truncates and all sums wrap mod 2^DATA_W
`default_nettype none

package ntm_trainer_pkg;

  ////////////////////////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////////////////////////

  localparam int DATA_W    = 16;  // Word width
  localparam int FRAC_BITS = 8;   // Fraction bits
  localparam int CNT_W     = 16;  // Time-step counter width

  typedef logic signed [DATA_W-1:0] data_t;

  localparam data_t ONE = data_t'(1 << FRAC_BITS);  // 1.0

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Run sequence of the controller
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACCUMULATE,  // Beats arriving
    ST_FLUSH,       // Pipeline emptying
    ST_DRAIN_W,     // dW read-out
    ST_DRAIN_B,     // db read-out
    ST_DONE
  } trainer_state_t;

  // Gradient selected for a read
  typedef enum logic {
    GRAD_W,
    GRAD_B
  } grad_kind_t;

  // Full signed product, arithmetic shift by FRAC_BITS, low DATA_W bits kept
  function automatic data_t fx_mul(data_t op_a, data_t op_b);
    logic signed [2*DATA_W-1:0] prod;
    prod = op_a * op_b;
    return data_t'(prod >>> FRAC_BITS);
  endfunction

endpackage

`default_nettype wire

// File: verilog/ntm_trainer_if.sv
// Index widths follow SIZE_L and SIZE_X, which must match the connected modules
`timescale 1ns/100ps
`default_nettype none

// Sampled beat, control to gate derivative
interface ntm_sample_if #(parameter int SIZE_L = 4, parameter int SIZE_X = 4);
  import ntm_trainer_pkg::*;
  localparam int L_W = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;
  localparam int X_W = (SIZE_X > 1) ? $clog2(SIZE_X) : 1;

  logic           valid;  // One strobe per beat
  logic [L_W-1:0] l_idx;
  logic [X_W-1:0] x_idx;
  data_t          s;      // State-error derivative
  data_t          a;      // Activation
  data_t          i;      // Input gate
  data_t          x;      // Input element

  modport src (output valid, l_idx, x_idx, s, a, i, x);
  modport dst (input  valid, l_idx, x_idx, s, a, i, x);
endinterface

// Gate delta with its operand x, gate derivative to accumulator
interface ntm_grad_if #(parameter int SIZE_L = 4, parameter int SIZE_X = 4);
  import ntm_trainer_pkg::*;
  localparam int L_W = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;
  localparam int X_W = (SIZE_X > 1) ? $clog2(SIZE_X) : 1;

  logic           valid;
  logic [L_W-1:0] l_idx;
  logic [X_W-1:0] x_idx;
  data_t          di;
  data_t          x;

  modport src (output valid, l_idx, x_idx, di, x);
  modport dst (input  valid, l_idx, x_idx, di, x);
endinterface

// Clear and read requests, control to accumulator
interface ntm_acc_ctrl_if #(parameter int SIZE_L = 4, parameter int SIZE_X = 4);
  import ntm_trainer_pkg::*;
  localparam int L_W = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;
  localparam int X_W = (SIZE_X > 1) ? $clog2(SIZE_X) : 1;

  logic           clear;    // Zero both arrays
  logic           rd_en;
  grad_kind_t     rd_kind;
  logic [L_W-1:0] rd_l;
  logic [X_W-1:0] rd_x;

  modport src (output clear, rd_en, rd_kind, rd_l, rd_x);
  modport dst (input  clear, rd_en, rd_kind, rd_l, rd_x);
endinterface

`default_nettype wire

// File: verilog/ntm_trainer_control.sv
// Beats are expected in t, l, x order with no stall. START is taken only in idle or done
// T of zero skips accumulation and drains the cleared arrays
`timescale 1ns/100ps
`default_nettype none

module ntm_trainer_control #(
  parameter int SIZE_L = 4,
  parameter int SIZE_X = 4
) (
  input  wire                              CLK,
  input  wire                              RST,
  input  wire                              start,
  input  wire [ntm_trainer_pkg::CNT_W-1:0] size_t_in,
  input  wire                              in_valid,
  input  ntm_trainer_pkg::data_t           s_in,
  input  ntm_trainer_pkg::data_t           a_in,
  input  ntm_trainer_pkg::data_t           i_in,
  input  ntm_trainer_pkg::data_t           x_in,
  output logic                             ready,
  ntm_sample_if.src                        sample,
  ntm_acc_ctrl_if.src                      acc_ctrl
);
  import ntm_trainer_pkg::*;

  localparam int L_W          = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;
  localparam int X_W          = (SIZE_X > 1) ? $clog2(SIZE_X) : 1;
  localparam int FLUSH_CYCLES = 3;  // Sample, stage 1, stage 2

  trainer_state_t state;
  logic [L_W-1:0] l_cnt;
  logic [X_W-1:0] x_cnt;
  logic [CNT_W-1:0] t_cnt;
  logic [CNT_W-1:0] t_len;    // Time steps of this run
  logic [1:0]     flush_cnt;
  logic           ready_pre;  // Last b read issued

  logic start_ok;
  logic beat;
  logic x_last;
  logic l_last;
  logic t_last;

  assign start_ok = start && ((state == ST_IDLE) || (state == ST_DONE));
  assign beat     = in_valid && (state == ST_ACCUMULATE);  // Strobes elsewhere dropped
  assign x_last   = (x_cnt == X_W'(SIZE_X - 1));
  assign l_last   = (l_cnt == L_W'(SIZE_L - 1));
  assign t_last   = (t_cnt == t_len - 1'b1);

  ////////////////////////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      t_len <= '0;
    end else begin
      case (state)
        ST_IDLE, ST_DONE: begin
          if (start_ok) begin
            t_len <= size_t_in;
            state <= (size_t_in == '0) ? ST_FLUSH : ST_ACCUMULATE;
          end
        end
        ST_ACCUMULATE: if (beat && x_last && l_last && t_last) state <= ST_FLUSH;
        ST_FLUSH:      if (flush_cnt == 2'(FLUSH_CYCLES - 1)) state <= ST_DRAIN_W;
        ST_DRAIN_W:    if (x_last && l_last) state <= ST_DRAIN_B;
        ST_DRAIN_B:    if (l_last) state <= ST_DONE;
        default:       state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Index counters
  ////////////////////////////////////////////////////////////

  // x fastest, then l, then t. Both drains reuse l and x as the read address
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      x_cnt     <= '0;
      l_cnt     <= '0;
      t_cnt     <= '0;
      flush_cnt <= '0;
    end else begin
      flush_cnt <= (state == ST_FLUSH) ? flush_cnt + 1'b1 : 2'd0;
      if (start_ok) begin
        x_cnt <= '0;
        l_cnt <= '0;
        t_cnt <= '0;
      end else if (beat || (state == ST_DRAIN_W)) begin
        x_cnt <= x_last ? '0 : x_cnt + 1'b1;
        if (x_last) begin
          l_cnt <= l_last ? '0 : l_cnt + 1'b1;
          if (l_last && beat) t_cnt <= t_cnt + 1'b1;
        end
      end else if (state == ST_DRAIN_B) begin
        l_cnt <= l_last ? '0 : l_cnt + 1'b1;  // Ends back at zero
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Beat sampling
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) sample.valid <= 1'b0;
    else     sample.valid <= beat;
  end

  always_ff @(posedge CLK) begin
    sample.l_idx <= l_cnt;  // Tag with position in the stream
    sample.x_idx <= x_cnt;
    sample.s     <= s_in;
    sample.a     <= a_in;
    sample.i     <= i_in;
    sample.x     <= x_in;
  end

  ////////////////////////////////////////////////////////////
  // Accumulator control and ready
  ////////////////////////////////////////////////////////////

  assign acc_ctrl.clear   = start_ok;
  assign acc_ctrl.rd_en   = (state == ST_DRAIN_W) || (state == ST_DRAIN_B);
  assign acc_ctrl.rd_kind = (state == ST_DRAIN_B) ? GRAD_B : GRAD_W;
  assign acc_ctrl.rd_l    = l_cnt;
  assign acc_ctrl.rd_x    = x_cnt;  // Zero during the db drain

  // Last b word lands one cycle after its read, ready one cycle after that
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready_pre <= 1'b0;
      ready     <= 1'b0;
    end else begin
      ready_pre <= (state == ST_DRAIN_B) && l_last;
      ready     <= ready_pre;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ntm_gate_derivative.sv
// Fixed two-cycle latency, one beat per cycle, no stall
`timescale 1ns/100ps
`default_nettype none

module ntm_gate_derivative #(
  parameter int SIZE_L = 4,
  parameter int SIZE_X = 4
) (
  input wire        CLK,
  input wire        RST,
  ntm_sample_if.dst sample,
  ntm_grad_if.src   grad
);
  import ntm_trainer_pkg::*;

  localparam int L_W = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;
  localparam int X_W = (SIZE_X > 1) ? $clog2(SIZE_X) : 1;

  // Stage 1 registers
  logic           st1_valid;
  data_t          st1_p;  // s*a
  data_t          st1_q;  // i*(1-i)
  logic [L_W-1:0] st1_l_idx;
  logic [X_W-1:0] st1_x_idx;
  data_t          st1_x;

  data_t one_minus_i;

  assign one_minus_i = data_t'(ONE - sample.i);  // Wraps like every other sum

  ////////////////////////////////////////////////////////////
  // Valid pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      st1_valid  <= 1'b0;
      grad.valid <= 1'b0;
    end else begin
      st1_valid  <= sample.valid;
      grad.valid <= st1_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////

  // Stage 1, the two independent products
  always_ff @(posedge CLK) begin
    st1_p     <= fx_mul(sample.s, sample.a);
    st1_q     <= fx_mul(sample.i, one_minus_i);
    st1_l_idx <= sample.l_idx;
    st1_x_idx <= sample.x_idx;
    st1_x     <= sample.x;
  end

  // Stage 2, di = trunc(p*q)
  always_ff @(posedge CLK) begin
    grad.di    <= fx_mul(st1_p, st1_q);
    grad.l_idx <= st1_l_idx;
    grad.x_idx <= st1_x_idx;
    grad.x     <= st1_x;  // Outer-product operand for dW
  end

endmodule

`default_nettype wire

// File: verilog/ntm_gradient_accumulator.sv
// Clear takes priority over a beat in the same cycle. Reads have one cycle of latency
`timescale 1ns/100ps
`default_nettype none

module ntm_gradient_accumulator #(
  parameter int SIZE_L = 4,
  parameter int SIZE_X = 4
) (
  input  wire                    CLK,
  input  wire                    RST,
  ntm_grad_if.dst                grad,
  ntm_acc_ctrl_if.dst            acc_ctrl,
  output ntm_trainer_pkg::data_t w_out,
  output ntm_trainer_pkg::data_t b_out,
  output logic                   w_out_enable,
  output logic                   b_out_enable
);
  import ntm_trainer_pkg::*;

  data_t w_mem [SIZE_L][SIZE_X];  // dW(l;x)
  data_t b_mem [SIZE_L];          // db(l)

  data_t w_term;
  logic  rd_w;
  logic  rd_b;

  assign w_term = fx_mul(grad.di, grad.x);  // Outer-product element
  assign rd_w   = acc_ctrl.rd_en && (acc_ctrl.rd_kind == GRAD_W);
  assign rd_b   = acc_ctrl.rd_en && (acc_ctrl.rd_kind == GRAD_B);

  ////////////////////////////////////////////////////////////
  // Accumulation
  ////////////////////////////////////////////////////////////

  // Arrays start at zero after reset and after every clear
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < SIZE_L; l++) begin
        b_mem[l] <= '0;
        for (int x = 0; x < SIZE_X; x++) w_mem[l][x] <= '0;
      end
    end else if (acc_ctrl.clear) begin
      for (int l = 0; l < SIZE_L; l++) begin
        b_mem[l] <= '0;
        for (int x = 0; x < SIZE_X; x++) w_mem[l][x] <= '0;
      end
    end else if (grad.valid) begin
      w_mem[grad.l_idx][grad.x_idx] <= w_mem[grad.l_idx][grad.x_idx] + w_term;
      // db takes di once per (t;l), on the x == 0 beat
      if (grad.x_idx == '0) b_mem[grad.l_idx] <= b_mem[grad.l_idx] + grad.di;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read-out
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_out_enable <= 1'b0;
      b_out_enable <= 1'b0;
    end else begin
      w_out_enable <= rd_w;
      b_out_enable <= rd_b;
    end
  end

  // Words hold their last value between reads
  always_ff @(posedge CLK) begin
    if (rd_w) w_out <= w_mem[acc_ctrl.rd_l][acc_ctrl.rd_x];
    if (rd_b) b_out <= b_mem[acc_ctrl.rd_l];
  end

endmodule

`default_nettype wire

// File: verilog/ntm_input_trainer.sv
// Input-gate trainer. Beats in t, l, x order, then dW l-major, db, and a ready pulse
// No back-pressure, so in_valid must only be raised for real beats
`timescale 1ns/100ps
`default_nettype none

module ntm_input_trainer #(
  parameter int SIZE_L = 4,  // Controller elements
  parameter int SIZE_X = 4   // Input elements
) (
  input  wire                              CLK,
  input  wire                              RST,
  input  wire                              start,
  input  wire [ntm_trainer_pkg::CNT_W-1:0] size_t_in,    // T, sampled on start
  input  wire                              in_valid,
  input  ntm_trainer_pkg::data_t           s_in,
  input  ntm_trainer_pkg::data_t           a_in,
  input  ntm_trainer_pkg::data_t           i_in,
  input  ntm_trainer_pkg::data_t           x_in,
  output logic                             ready,
  output logic                             w_out_enable,
  output logic                             b_out_enable,
  output ntm_trainer_pkg::data_t           w_out,
  output ntm_trainer_pkg::data_t           b_out
);

  ////////////////////////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////////////////////////

  ntm_sample_if   #(.SIZE_L(SIZE_L), .SIZE_X(SIZE_X)) sample_bus ();
  ntm_grad_if     #(.SIZE_L(SIZE_L), .SIZE_X(SIZE_X)) grad_bus ();
  ntm_acc_ctrl_if #(.SIZE_L(SIZE_L), .SIZE_X(SIZE_X)) acc_ctrl_bus ();

  ////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////

  ntm_trainer_control #(.SIZE_L(SIZE_L), .SIZE_X(SIZE_X)) i_control (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .size_t_in(size_t_in),
    .in_valid (in_valid),
    .s_in     (s_in),
    .a_in     (a_in),
    .i_in     (i_in),
    .x_in     (x_in),
    .ready    (ready),
    .sample   (sample_bus.src),
    .acc_ctrl (acc_ctrl_bus.src)
  );

  // Two cycles, sample to di
  ntm_gate_derivative #(.SIZE_L(SIZE_L), .SIZE_X(SIZE_X)) i_gate_derivative (
    .CLK   (CLK),
    .RST   (RST),
    .sample(sample_bus.dst),
    .grad  (grad_bus.src)
  );

  ntm_gradient_accumulator #(.SIZE_L(SIZE_L), .SIZE_X(SIZE_X)) i_accumulator (
    .CLK         (CLK),
    .RST         (RST),
    .grad        (grad_bus.dst),
    .acc_ctrl    (acc_ctrl_bus.dst),
    .w_out       (w_out),
    .b_out       (b_out),
    .w_out_enable(w_out_enable),
    .b_out_enable(b_out_enable)
  );

endmodule

`default_nettype wire

// File: dv/ntm_input_trainer_tb.sv
// Runs the two trainer runs from the stimulus file with default SIZE_L = SIZE_X = 4
// Expected words are recomputed here from the beats and checked against the file first
`timescale 1ns/100ps
`default_nettype none

module ntm_input_trainer_tb;
  import ntm_trainer_pkg::*;

  localparam int NL        = 4;
  localparam int NX        = 4;
  localparam int NW        = NL * NX;  // dW words per run
  localparam int MAX_BEATS = 64;
  localparam int TIMEOUT   = 400;      // Cycles allowed for a read-out

  logic                CLK;
  logic                RST;
  logic                start;
  logic [CNT_W-1:0]    size_t_in;
  logic                in_valid;
  data_t               s_in;
  data_t               a_in;
  data_t               i_in;
  data_t               x_in;
  logic                ready;
  logic                w_out_enable;
  logic                b_out_enable;
  data_t               w_out;
  data_t               b_out;

  integer seed = 32'hf3bf;

  // Runs as read from the file, index 0 is run 1
  int    run_t [2];
  data_t beat_s [2][MAX_BEATS];
  data_t beat_a [2][MAX_BEATS];
  data_t beat_i [2][MAX_BEATS];
  data_t beat_x [2][MAX_BEATS];
  data_t exp_w [2][NW];
  data_t exp_b [2][NL];

  // Captured read-out
  data_t got_w [NW];
  data_t got_b [NL];
  int    nw;
  int    nb;
  int    nready;
  bit    order_bad;
  bit    timed_out;

  int test_errs;
  int pass_cnt;
  int fail_cnt;
  int fd;
  bit file_err;

  ntm_input_trainer i_ntm_input_trainer (
    .CLK(CLK), .RST(RST), .start(start), .size_t_in(size_t_in), .in_valid(in_valid),
    .s_in(s_in), .a_in(a_in), .i_in(i_in), .x_in(x_in), .ready(ready),
    .w_out_enable(w_out_enable), .b_out_enable(b_out_enable), .w_out(w_out), .b_out(b_out)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Reference arithmetic and file reading
  ////////////////////////////////////////////////////////////

  // Q8.8 product, arithmetic shift, low 16 bits
  function automatic data_t mul_trunc(data_t op_a, data_t op_b);
    logic signed [31:0] full;
    full = op_a * op_b;
    return data_t'(full >>> FRAC_BITS);
  endfunction

  task automatic read_hex(output logic [31:0] v);
    int code;
    code = $fscanf(fd, "%h", v);
    if (code != 1) file_err = 1'b1;
  endtask

  task automatic load_run(input int r);
    logic [31:0] v;
    read_hex(v);
    run_t[r] = int'(v);
    for (int k = 0; k < run_t[r] * NW; k++) begin
      read_hex(v);
      beat_s[r][k] = data_t'(v);
      read_hex(v);
      beat_a[r][k] = data_t'(v);
      read_hex(v);
      beat_i[r][k] = data_t'(v);
      read_hex(v);
      beat_x[r][k] = data_t'(v);
    end
    for (int k = 0; k < NW; k++) begin
      read_hex(v);
      exp_w[r][k] = data_t'(v);
    end
    for (int k = 0; k < NL; k++) begin
      read_hex(v);
      exp_b[r][k] = data_t'(v);
    end
  endtask

  // Recompute dW and db from the beats, compare with the file's words
  task automatic verify_run(input int r);
    data_t w_m [NW];
    data_t b_m [NL];
    data_t p;
    data_t q;
    data_t di;
    int    l;
    int    x;
    for (int k = 0; k < NW; k++) w_m[k] = '0;
    for (int k = 0; k < NL; k++) b_m[k] = '0;
    for (int k = 0; k < run_t[r] * NW; k++) begin
      x  = k % NX;
      l  = (k / NX) % NL;
      p  = mul_trunc(beat_s[r][k], beat_a[r][k]);
      q  = mul_trunc(beat_i[r][k], data_t'(ONE - beat_i[r][k]));
      di = mul_trunc(p, q);
      w_m[l*NX+x] = data_t'(w_m[l*NX+x] + mul_trunc(di, beat_x[r][k]));
      if (x == 0) b_m[l] = data_t'(b_m[l] + di);
    end
    for (int k = 0; k < NW; k++) begin
      if (w_m[k] !== exp_w[r][k]) begin
        $display("[FAIL] file dW[%0d] run %0d: model 0x%h, file 0x%h",
                 k, r+1, w_m[k], exp_w[r][k]);
        test_errs++;
      end
    end
    for (int k = 0; k < NL; k++) begin
      if (b_m[k] !== exp_b[r][k]) begin
        $display("[FAIL] file db[%0d] run %0d: model 0x%h, file 0x%h",
                 k, r+1, b_m[k], exp_b[r][k]);
        test_errs++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driving and collecting
  ////////////////////////////////////////////////////////////

  task automatic send_run(input int r, input bit gaps);
    int gap;
    @(posedge CLK);
    start     <= 1'b1;
    size_t_in <= CNT_W'(run_t[r]);
    @(posedge CLK);
    start <= 1'b0;
    for (int k = 0; k < run_t[r] * NW; k++) begin
      gap = gaps ? int'($unsigned($random(seed)) % 3) : 0;
      repeat (gap) begin
        in_valid <= 1'b0;
        @(posedge CLK);
      end
      in_valid <= 1'b1;
      s_in     <= beat_s[r][k];
      a_in     <= beat_a[r][k];
      i_in     <= beat_i[r][k];
      x_in     <= beat_x[r][k];
      @(posedge CLK);
    end
    in_valid <= 1'b0;
  endtask

  // Sampled on the falling edge, away from the driving edge
  task automatic collect_results();
    int cyc;
    nw        = 0;
    nb        = 0;
    nready    = 0;
    order_bad = 1'b0;
    cyc       = 0;
    while (nready == 0 && cyc < TIMEOUT) begin
      @(negedge CLK);
      cyc++;
      if (w_out_enable) begin
        if (nw < NW) got_w[nw] = w_out;
        nw++;
      end
      if (b_out_enable) begin
        if (nw < NW) order_bad = 1'b1;  // db before all of dW
        if (nb < NL) got_b[nb] = b_out;
        nb++;
      end
      if (ready) nready++;
    end
    timed_out = (nready == 0);
    repeat (8) begin  // Look for a second pulse
      @(negedge CLK);
      if (ready) nready++;
    end
  endtask

  task automatic check_w(input int r);
    if (timed_out) begin
      $display("Read-out of run %0d did not end with ready within %0d cycles", r+1, TIMEOUT);
      test_errs++;
    end
    if (nw != NW) begin
      $display("[FAIL] w_out_enable count: expected 0x%h, got 0x%h", NW, nw);
      test_errs++;
    end
    for (int k = 0; k < NW && k < nw; k++) begin
      if (got_w[k] !== exp_w[r][k]) begin
        $display("[FAIL] w_out[%0d]: expected 0x%h, got 0x%h", k, exp_w[r][k], got_w[k]);
        test_errs++;
      end
    end
  endtask

  task automatic check_b(input int r);
    if (order_bad) begin
      $display("A b_out word arrived before all w_out words");
      test_errs++;
    end
    if (nb != NL) begin
      $display("[FAIL] b_out_enable count: expected 0x%h, got 0x%h", NL, nb);
      test_errs++;
    end
    for (int k = 0; k < NL && k < nb; k++) begin
      if (got_b[k] !== exp_b[r][k]) begin
        $display("[FAIL] b_out[%0d]: expected 0x%h, got 0x%h", k, exp_b[r][k], got_b[k]);
        test_errs++;
      end
    end
    if (nready != 1) begin
      $display("[FAIL] ready pulses: expected 0x%h, got 0x%h", 1, nready);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("ok    %s", name);
    end else begin
      fail_cnt++;
      $display("fail  %s (%0d errors)", name, test_errs);
    end
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST       = 1'b1;
    start     = 1'b0;
    size_t_in = '0;
    in_valid  = 1'b0;
    s_in      = '0;
    a_in      = '0;
    i_in      = '0;
    x_in      = '0;
    test_errs = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    file_err  = 1'b0;

    // Stimulus file, two header lines then the runs
    fd = $fopen("dv/ntm_input_trainer_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      test_errs++;
    end else begin
      string hdr;
      if ($fgets(hdr, fd) == 0) file_err = 1'b1;
      if ($fgets(hdr, fd) == 0) file_err = 1'b1;
      load_run(0);
      load_run(1);
      $fclose(fd);
      if (file_err) begin
        $display("The stimulus file ended early or held a bad token");
        test_errs++;
      end else begin
        verify_run(0);
        verify_run(1);
      end
    end
    finish_test("stimulus file matches the reference model");

    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // 1: quiet outputs, in_valid toggling with no run
    repeat (10) begin
      @(posedge CLK);
      in_valid <= 1'($random(seed));
      @(negedge CLK);
      if (ready || w_out_enable || b_out_enable) begin
        $display("An output strobe rose with no run active");
        test_errs++;
      end
    end
    @(posedge CLK);
    in_valid <= 1'b0;
    finish_test("test 1 outputs idle after reset");

    if (!file_err && fd != 0) begin
      send_run(0, 1'b0);
      collect_results();
      check_w(0);
      finish_test("test 2 run 1 dW words");
      check_b(0);
      finish_test("test 3 run 1 db words and ready");

      // Run 2 straight after, arrays must restart from zero
      send_run(1, 1'b1);
      collect_results();
      check_w(1);
      check_b(1);
      finish_test("test 4 run 2 with gaps");

      // Stray strobes between runs, still high in the cycle that start is taken
      repeat (6) begin
        @(posedge CLK);
        in_valid <= 1'b1;
        s_in     <= data_t'($random(seed));
        a_in     <= data_t'($random(seed));
        i_in     <= data_t'($random(seed));
        x_in     <= data_t'($random(seed));
      end
      send_run(1, 1'b1);
      collect_results();
      check_w(1);
      check_b(1);
      finish_test("test 5 run 2 replayed after stray strobes");
    end

    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/ntm_input_trainer_stimulus.txt
// Per run: T, then one line per (t;l) with four beats s a i x (x index 0..3), t outermost
// Then SIZE_L lines of expected dW (x 0..3 per l) and one line of expected db (l 0..3)
0002
0040 0100 0080 0100  0040 0100 0080 0200  0040 0100 0080 ff00  0040 0100 0080 0300
0080 0100 0080 0100  0080 0100 0080 0200  0080 0100 0080 ff00  0080 0100 0080 0300
ffc0 0100 0080 0100  ffc0 0100 0080 0200  ffc0 0100 0080 ff00  ffc0 0100 0080 0300
0100 0100 0080 0100  0100 0100 0080 0200  0100 0100 0080 ff00  0100 0100 0080 0300
0020 0100 0080 0100  0020 0100 0080 0200  0020 0100 0080 ff00  0020 0100 0080 0300
ff80 0100 0080 0100  ff80 0100 0080 0200  ff80 0100 0080 ff00  ff80 0100 0080 0300
0200 0100 0080 0100  0200 0100 0080 0200  0200 0100 0080 ff00  0200 0100 0080 0300
0004 0100 0080 0100  0004 0100 0080 0200  0004 0100 0080 ff00  0004 0100 0080 0300
0018 0030 ffe8 0048
0000 0000 0000 0000
0070 00e0 ff90 0150
0041 0082 ffbf 00c3
0018 0000 0070 0041
0001
0010 0200 0080 0100  0010 0200 0080 0200  0010 0200 0080 ff00  0010 0200 0080 0300
fff0 0200 0080 0100  fff0 0200 0080 0200  fff0 0200 0080 ff00  fff0 0200 0080 0300
0300 0200 0080 0100  0300 0200 0080 0200  0300 0200 0080 ff00  0300 0200 0080 0300
0008 0200 0080 0100  0008 0200 0080 0200  0008 0200 0080 ff00  0008 0200 0080 0300
0008 0010 fff8 0018
fff8 fff0 0008 ffe8
0180 0300 fe80 0480
0004 0008 fffc 000c
0008 fff8 0180 0004

// File: all.f
verilog/ntm_trainer_pkg.sv
verilog/ntm_trainer_if.sv
verilog/ntm_trainer_control.sv
verilog/ntm_gate_derivative.sv
verilog/ntm_gradient_accumulator.sv
verilog/ntm_input_trainer.sv
dv/ntm_input_trainer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the trainer testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --top-module ntm_input_trainer_tb \
  -f all.f \
  -o sim_ntm_input_trainer

./obj_dir/sim_ntm_input_trainer | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
